// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    // Datapath and register file sizes
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    // One enable bit per byte lane, lane 0 is the low byte
    typedef logic [3:0]      byte_en_t;

    // Major opcodes handled by the core
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // Access width, low two bits of funct3
    localparam logic [1:0] MEM_BYTE = 2'b00;
    localparam logic [1:0] MEM_HALF = 2'b01;
    localparam logic [1:0] MEM_WORD = 2'b10;

    // Encoding is {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_t;

    // Instruction word seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            reg_addr_t   rs1;
            logic [2:0]  funct3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic [19:0] imm20;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } u_fmt;
    } instr_t;

    // Decoded control for one instruction
    typedef struct packed {
        alu_op_t    alu_op;
        logic       src1_is_pc;
        logic       src2_is_imm;
        word_t      imm;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        logic       reg_we;
        logic       is_load;
        logic       is_store;
        logic [1:0] mem_size;
        logic       mem_unsigned;
    } ctrl_t;

    // Data memory request, be doubles as the write strobe
    typedef struct packed {
        word_t    addr;
        word_t    wdata;
        byte_en_t be;
    } mem_req_t;

endpackage

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  cpu_pkg::instr_t instr,
    output cpu_pkg::ctrl_t  ctrl
);
    import cpu_pkg::*;

    // Fields shared by every format
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;

    // Candidate immediates, one per format
    word_t imm_i;
    word_t imm_s;
    word_t imm_u;
    word_t imm_shamt;

    // Shift immediates are funct3 001 and 101
    logic is_shift_f3;
    // Only ADD/SUB and SRL/SRA use bit 30 in OP
    logic uses_b30;

    assign opcode    = instr.r_fmt.opcode;
    assign funct3    = instr.r_fmt.funct3;
    assign funct7_b5 = instr.r_fmt.funct7[5];

    // I-type, sign extended from bit 31
    assign imm_i = {{(XLEN-12){instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};

    // S-type, split field joined then sign extended
    assign imm_s = {{(XLEN-12){instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi,
                    instr.s_fmt.imm_lo};

    // U-type, upper twenty bits with zero low part
    assign imm_u = {instr.u_fmt.imm20, 12'b0};

    // Shift amount sits in the rs2 position, no sign extension
    assign imm_shamt = {{(XLEN-5){1'b0}}, instr.i_fmt.imm12[4:0]};

    assign is_shift_f3 = (funct3[1:0] == 2'b01);
    assign uses_b30    = (funct3 == 3'b000) || (funct3 == 3'b101);

    always_comb begin
        // Defaults describe a NOP
        ctrl              = '0;
        ctrl.alu_op       = ALU_ADD;
        ctrl.rs1          = instr.r_fmt.rs1;
        ctrl.rs2          = instr.r_fmt.rs2;
        ctrl.rd           = instr.r_fmt.rd;
        ctrl.mem_size     = funct3[1:0];
        ctrl.mem_unsigned = funct3[2];

        case (opcode)
            OPC_LUI: begin
                // x0 plus immediate
                ctrl.rs1         = '0;
                ctrl.rd          = instr.u_fmt.rd;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = imm_u;
                ctrl.reg_we      = 1'b1;
            end
            OPC_AUIPC: begin
                // PC plus immediate
                ctrl.rd          = instr.u_fmt.rd;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = imm_u;
                ctrl.reg_we      = 1'b1;
            end
            OPC_OP: begin
                ctrl.alu_op = alu_op_t'({funct7_b5 & uses_b30, funct3});
                ctrl.reg_we = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.rd          = instr.i_fmt.rd;
                ctrl.src2_is_imm = 1'b1;
                ctrl.reg_we      = 1'b1;
                if (is_shift_f3) begin
                    // SRAI only when funct3 is 101
                    ctrl.alu_op = alu_op_t'({funct7_b5 & funct3[2], funct3});
                    ctrl.imm    = imm_shamt;
                end else begin
                    ctrl.alu_op = alu_op_t'({1'b0, funct3});
                    ctrl.imm    = imm_i;
                end
            end
            OPC_LOAD: begin
                // Address is rs1 plus offset
                ctrl.rd          = instr.i_fmt.rd;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = imm_i;
                ctrl.reg_we      = 1'b1;
                ctrl.is_load     = 1'b1;
            end
            OPC_STORE: begin
                // No writeback, rs2 carries the data
                ctrl.rs2         = instr.s_fmt.rs2;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = imm_s;
                ctrl.is_store    = 1'b1;
            end
            default: begin
                // Unknown opcode stays a NOP
                ctrl.reg_we   = 1'b0;
                ctrl.is_store = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   result
);
    import cpu_pkg::*;

    // Only the low five bits shift
    logic [4:0] shamt;

    // Comparison results
    logic lt_signed;
    logic lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                // Sign bit fills from the left
                result = word_t'($signed(a) >>> shamt);
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_AND: begin
                result = a & b;
            end
            default: begin
                result = a + b;
            end
        endcase
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
    parameter int DEPTH = 32
) (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    input  cpu_pkg::reg_addr_t rd,
    input  logic               we,
    input  cpu_pkg::word_t     wdata,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2
);
    import cpu_pkg::*;

    word_t regs [DEPTH];

    // Asynchronous reads, x0 forced to zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    // Single write port at the rising edge
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            // Writes to x0 are dropped
            regs[rd] <= wdata;
        end
    end

endmodule

// ==== logic/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit (
    input  logic              reset,
    input  cpu_pkg::ctrl_t    ctrl,
    input  cpu_pkg::word_t    addr,
    input  cpu_pkg::word_t    store_data,
    input  cpu_pkg::word_t    drdata,
    output cpu_pkg::mem_req_t dmem_req,
    output cpu_pkg::word_t    load_data
);
    import cpu_pkg::*;

    // Byte offset inside the aligned word
    logic [1:0] offset;
    // Offset in bits for lane shifting
    logic [4:0] bit_shift;

    byte_en_t store_be;
    word_t    store_wdata;
    // Read word moved down so the addressed byte is at bit 0
    word_t    rd_shifted;

    assign offset     = addr[1:0];
    assign bit_shift  = {offset, 3'b000};
    assign rd_shifted = drdata >> bit_shift;

    // Store lane enables and data placement
    always_comb begin
        store_wdata = store_data << bit_shift;
        case (ctrl.mem_size)
            MEM_BYTE: begin
                store_be = byte_en_t'(4'b0001 << offset);
            end
            MEM_HALF: begin
                // Upper half would cross the word at offset 3
                if (offset == 2'b11) begin
                    store_be = '0;
                end else begin
                    store_be = byte_en_t'(4'b0011 << offset);
                end
            end
            MEM_WORD: begin
                // Low address bits ignored
                store_be    = 4'b1111;
                store_wdata = store_data;
            end
            default: begin
                store_be = '0;
            end
        endcase
    end

    // Load lane extraction with sign or zero extension
    always_comb begin
        case (ctrl.mem_size)
            MEM_BYTE: begin
                if (ctrl.mem_unsigned) begin
                    load_data = {{(XLEN-8){1'b0}}, rd_shifted[7:0]};
                end else begin
                    load_data = {{(XLEN-8){rd_shifted[7]}}, rd_shifted[7:0]};
                end
            end
            MEM_HALF: begin
                if (ctrl.mem_unsigned) begin
                    load_data = {{(XLEN-16){1'b0}}, rd_shifted[15:0]};
                end else begin
                    load_data = {{(XLEN-16){rd_shifted[15]}}, rd_shifted[15:0]};
                end
            end
            default: begin
                // Whole aligned word
                load_data = drdata;
            end
        endcase
    end

    // Memory sees the full address, it picks the aligned word itself
    assign dmem_req.addr  = addr;
    assign dmem_req.wdata = store_wdata;
    // Strobe only for stores, and never while in reset
    assign dmem_req.be    = (ctrl.is_store && !reset) ? store_be : '0;

endmodule

// ==== logic/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core #(
    parameter cpu_pkg::word_t RESET_ADDR = '0
) (
    input  logic              clk,
    input  logic              reset,
    output cpu_pkg::word_t    iaddr,
    input  cpu_pkg::instr_t   idata,
    output cpu_pkg::mem_req_t dmem_req,
    input  cpu_pkg::word_t    drdata
);
    import cpu_pkg::*;

    // Program counter
    word_t pc;

    // Decoded control
    ctrl_t ctrl;

    // Register file read values
    word_t rdata1;
    word_t rdata2;

    // ALU operands and result
    word_t op_a;
    word_t op_b;
    word_t alu_result;

    // Writeback path
    word_t load_data;
    word_t wb_data;
    logic  reg_we;

    // Fetch address is the PC itself
    assign iaddr = pc;

    // No branches, so the PC only steps forward
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_ADDR;
        end else begin
            pc <= pc + word_t'(4);
        end
    end

    instr_decoder u_instr_decoder (
        .instr (idata),
        .ctrl  (ctrl)
    );

    reg_file #(
        .DEPTH (NUM_REGS)
    ) u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .rs1    (ctrl.rs1),
        .rs2    (ctrl.rs2),
        .rd     (ctrl.rd),
        .we     (reg_we),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    // AUIPC takes the PC, everything else rs1
    assign op_a = ctrl.src1_is_pc ? pc : rdata1;
    // Immediate or rs2
    assign op_b = ctrl.src2_is_imm ? ctrl.imm : rdata2;

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    // ALU result doubles as the data address
    load_store_unit u_load_store_unit (
        .reset      (reset),
        .ctrl       (ctrl),
        .addr       (alu_result),
        .store_data (rdata2),
        .drdata     (drdata),
        .dmem_req   (dmem_req),
        .load_data  (load_data)
    );

    // Loads write memory data, all others the ALU result
    assign wb_data = ctrl.is_load ? load_data : alu_result;
    // No register update while reset is held
    assign reg_we  = ctrl.reg_we & ~reset;

endmodule

// ==== verif/tb_ref_model.svh ====
// Reference model state, advanced by one instruction per call
word_t ref_regs [NUM_REGS];
word_t ref_mem [256];
word_t ref_pc;

// Uniform pick in 0 to n-1 from the seeded stream
function automatic int rnd(input int n);
    return int'($unsigned($random(seed)) % n);
endfunction

// Any register except x0 and the x1 base pointer
function automatic reg_addr_t pick_reg();
    return reg_addr_t'(2 + rnd(30));
endfunction

function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

// Byte enables widened to a bit mask
function automatic word_t lane_mask(input byte_en_t be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
endfunction

// RV32I result for funct3 and the funct7 alternate bit
function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return word_t'($signed(a) < $signed(b));
        3'd3: return word_t'(a < b);
        3'd4: return a ^ b;
        3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// Executes one instruction and reports the store it should issue
task automatic ref_step(input instr_t ins, output logic st, output word_t st_addr,
                        output byte_en_t st_be, output word_t st_data);
    word_t ea;
    word_t a;
    word_t b;
    word_t res;
    word_t raw;
    logic  wr;
    int    lane;
    a       = ref_regs[ins.r_fmt.rs1];
    b       = ref_regs[ins.r_fmt.rs2];
    ea      = '0;
    res     = '0;
    wr      = 1'b1;
    st      = 1'b0;
    st_addr = '0;
    st_be   = '0;
    st_data = '0;
    case (ins.r_fmt.opcode)
        OPC_LUI: res = {ins.u_fmt.imm20, 12'h000};
        OPC_AUIPC: res = ref_pc + {ins.u_fmt.imm20, 12'h000};
        OPC_OP: res = ref_alu(ins.r_fmt.funct3, ins.r_fmt.funct7[5], a, b);
        OPC_OP_IMM: begin
            // Bit 30 only matters for SRAI
            res = ref_alu(ins.i_fmt.funct3, (ins.i_fmt.funct3 == 3'd5) && ins.r_fmt.funct7[5],
                          a, sext12(ins.i_fmt.imm12));
        end
        OPC_LOAD: begin
            ea  = a + sext12(ins.i_fmt.imm12);
            raw = ref_mem[ea[9:2]] >> {ea[1:0], 3'b000};
            case (ins.i_fmt.funct3)
                3'd0: res = {{24{raw[7]}}, raw[7:0]};
                3'd1: res = {{16{raw[15]}}, raw[15:0]};
                3'd4: res = {24'h000000, raw[7:0]};
                3'd5: res = {16'h0000, raw[15:0]};
                // LW ignores the low address bits
                default: res = ref_mem[ea[9:2]];
            endcase
        end
        OPC_STORE: begin
            ea      = a + sext12({ins.s_fmt.imm_hi, ins.s_fmt.imm_lo});
            wr      = 1'b0;
            st      = 1'b1;
            st_addr = ea;
            st_data = b << {ea[1:0], 3'b000};
            case (ins.s_fmt.funct3)
                3'd0: st_be = 4'b0001 << ea[1:0];
                // Halfword spilling past the word writes nothing
                3'd1: st_be = (ea[1:0] == 2'd3) ? 4'b0000 : 4'b0011 << ea[1:0];
                default: begin
                    st_be   = 4'b1111;
                    st_data = b;
                end
            endcase
            for (lane = 0; lane < 4; lane++) begin
                if (st_be[lane]) begin
                    ref_mem[ea[9:2]][8*lane +: 8] = st_data[8*lane +: 8];
                end
            end
        end
        // Unknown opcode is a NOP
        default: wr = 1'b0;
    endcase
    if (wr && (ins.r_fmt.rd != 5'd0)) begin
        ref_regs[ins.r_fmt.rd] = res;
    end
    ref_pc = ref_pc + 32'd4;
endtask

task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
        err_count++;
        $display("ERROR %s: expected %08h, actual %08h", name, exp, act);
    end
endtask

task automatic check_be(input string name, input byte_en_t exp, input byte_en_t act);
    if (act !== exp) begin
        err_count++;
        $display("ERROR %s: expected be %04b, actual be %04b", name, exp, act);
    end
endtask

task automatic emit(input instr_t ins);
    imem[prog_len]    = ins;
    test_of[prog_len] = cur_test;
    prog_len++;
endtask

// Store through the x1 base at a byte offset
task automatic emit_store(input reg_addr_t src, input logic [2:0] f3, input logic [11:0] off);
    emit({off[11:5], src, 5'd1, f3, off[4:0], OPC_STORE});
endtask

task automatic build_program();
    int          i;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] off;
    reg_addr_t   rd;
    for (i = 0; i < 256; i++) begin
        imem[i] = {12'h000, 5'd0, 3'd0, 5'd0, OPC_OP_IMM};
    end
    prog_len = 0;
    cur_test = "pc_sequence";
    // Instruction 0 is a store, fetched all through reset with its strobe held low
    emit({7'h00, 5'd0, 5'd0, 3'd2, 5'd0, OPC_STORE});
    // x1 points at the upper half of data memory
    emit({12'h200, 5'd0, 3'd0, 5'd1, OPC_OP_IMM});
    cur_test = "alu_reg_reg";
    for (i = 2; i < 32; i++) begin
        emit({20'($random(seed)), reg_addr_t'(i), OPC_LUI});
        emit({12'($random(seed)), reg_addr_t'(i), 3'd0, reg_addr_t'(i), OPC_OP_IMM});
    end
    for (i = 0; i < 40; i++) begin
        f3 = 3'(rnd(8));
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && rnd(2) == 1) ? 7'h20 : 7'h00;
        rd = pick_reg();
        emit({f7, reg_addr_t'(rnd(32)), reg_addr_t'(rnd(32)), f3, rd, OPC_OP});
        emit_store(rd, 3'd2, 12'(rnd(128) * 4));
    end
    cur_test = "alu_imm_upper";
    for (i = 0; i < 24; i++) begin
        f3 = 3'(rnd(8));
        rd = pick_reg();
        if (i >= 22) begin
            emit({20'($random(seed)), rd, OPC_AUIPC});
        end else if (i >= 20) begin
            emit({20'($random(seed)), rd, OPC_LUI});
        end else if (f3 == 3'd1 || f3 == 3'd5) begin
            // Shift amount in the low five immediate bits
            f7 = (f3 == 3'd5 && rnd(2) == 1) ? 7'h20 : 7'h00;
            emit({f7, 5'(rnd(32)), reg_addr_t'(rnd(32)), f3, rd, OPC_OP_IMM});
        end else begin
            emit({12'($random(seed)), reg_addr_t'(rnd(32)), f3, rd, OPC_OP_IMM});
        end
        emit_store(rd, 3'd2, 12'(rnd(128) * 4));
    end
    cur_test = "store_lanes";
    for (i = 0; i < 4; i++) begin
        emit_store(pick_reg(), 3'd0, 12'(rnd(128) * 4 + i));
        emit_store(pick_reg(), 3'd1, 12'(rnd(128) * 4 + i));
    end
    emit_store(pick_reg(), 3'd2, 12'(rnd(128) * 4));
    cur_test = "load_extend";
    for (i = 0; i < 16; i++) begin
        // LB and LBU at offsets 0-3, then LH and LHU at 0-2, then LW
        if (i < 8) begin
            f3  = {i[0], 2'b00};
            off = 12'(rnd(128) * 4 + i / 2);
        end else if (i < 14) begin
            f3  = {i[0], 2'b01};
            off = 12'(rnd(128) * 4 + (i - 8) / 2);
        end else begin
            f3  = 3'd2;
            off = 12'(rnd(128) * 4);
        end
        rd = pick_reg();
        emit({off, 5'd1, f3, rd, OPC_LOAD});
        emit_store(rd, 3'd2, 12'(rnd(128) * 4));
    end
    cur_test = "x0_and_nop";
    emit({12'($random(seed)), 5'd2, 3'd0, 5'd0, OPC_OP_IMM});
    emit({20'($random(seed)), 5'd0, OPC_LUI});
    emit({7'h00, 5'd2, 5'd3, 3'd0, 5'd0, OPC_OP});
    // Custom opcode naming x7 as rd
    emit({20'($random(seed)), 5'd7, 7'b1111011});
    emit_store(5'd0, 3'd2, 12'(rnd(128) * 4));
    emit_store(5'd7, 3'd2, 12'(rnd(128) * 4));
endtask

// ==== verif/tb_cpu_core.sv ====
`timescale 1ns/1ps

module tb_cpu_core;
    import cpu_pkg::*;

    logic     clk = 1'b0;
    logic     reset;
    word_t    iaddr;
    instr_t   idata;
    mem_req_t dmem_req;
    word_t    drdata;

    // Separate instruction and data memories
    instr_t imem [256];
    word_t  dmem [256];

    integer seed;
    int     prog_len;
    int     err_count;
    int     cycles;
    int     max_cycles;
    int     edge_count;
    string  cur_test;
    string  test_of [256];

    // Expected results for the instruction in flight
    word_t    exp_pc;
    logic     exp_st;
    word_t    exp_addr;
    byte_en_t exp_be;
    word_t    exp_data;

    `include "tb_ref_model.svh"

    cpu_core #(
        .RESET_ADDR (32'h0000_0000)
    ) u_cpu_core (
        .clk      (clk),
        .reset    (reset),
        .iaddr    (iaddr),
        .idata    (idata),
        .dmem_req (dmem_req),
        .drdata   (drdata)
    );

    // Both memories answer within the cycle
    assign idata  = imem[iaddr[9:2]];
    assign drdata = dmem[dmem_req.addr[9:2]];

    // Byte lanes written at the rising edge
    always @(posedge clk) begin : dmem_write
        int lane;
        for (lane = 0; lane < 4; lane++) begin
            if (dmem_req.be[lane]) begin
                dmem[dmem_req.addr[9:2]][8*lane +: 8] <= dmem_req.wdata[8*lane +: 8];
            end
        end
    end

    initial begin
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin : stimulus
        int i;
        reset      = 1'b1;
        seed       = 30;
        err_count  = 0;
        cycles     = 0;
        edge_count = 0;
        ref_pc     = 32'h0000_0000;
        for (i = 0; i < NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end
        for (i = 0; i < 256; i++) begin
            dmem[i]    = $random(seed);
            ref_mem[i] = dmem[i];
        end
        build_program();
        // Program length plus reset plus margin
        max_cycles = prog_len + 3 + 20;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

    always @(posedge clk) begin : watchdog
        cycles++;
        if (cycles > max_cycles) begin
            $display("Timeout: program not finished after %0d cycles", max_cycles);
            $display("Run ended with %0d errors", err_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin : compare
        edge_count++;
        if (edge_count < 3) begin
            // Still in reset, the store at address 0 must not strobe
            check_be("pc_sequence", 4'b0000, dmem_req.be);
            check_word("pc_sequence", 32'h0000_0000, iaddr);
        end else begin
            exp_pc = ref_pc;
            ref_step(imem[exp_pc[9:2]], exp_st, exp_addr, exp_be, exp_data);
            check_word("pc_sequence", exp_pc, iaddr);
            // Reset drops at edge 3 and the strobe of instruction 0 is only checked before
            if (edge_count > 3) begin
                if (exp_st) begin
                    check_word(test_of[exp_pc[9:2]], {exp_addr[31:2], 2'b00},
                               {dmem_req.addr[31:2], 2'b00});
                    check_be(test_of[exp_pc[9:2]], exp_be, dmem_req.be);
                    check_word(test_of[exp_pc[9:2]], exp_data & lane_mask(exp_be),
                               dmem_req.wdata & lane_mask(dmem_req.be));
                end else begin
                    check_be(test_of[exp_pc[9:2]], 4'b0000, dmem_req.be);
                end
            end
            if (ref_pc == word_t'(prog_len * 4)) begin
                $display("Run ended with %0d errors over %0d instructions", err_count, prog_len);
                if (err_count == 0) begin
                    $display("TESTBENCH PASSED");
                end else begin
                    $display("TESTBENCH FAILED");
                end
                $finish;
            end
        end
    end

endmodule

// ==== list.f ====
+incdir+verif
logic/cpu_pkg.sv
logic/instr_decoder.sv
logic/alu.sv
logic/reg_file.sv
logic/load_store_unit.sv
logic/cpu_core.sv
verif/tb_cpu_core.sv
